//--- flist.f
hdl/cpu_pkg.sv
hdl/bus_pkg.sv
hdl/alu.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/fetch_unit.sv
hdl/s1c88_core.sv
bench/s1c88_checker.sv
bench/s1c88_tb.sv

//--- Makefile
# Verilator build and run of the S1C88 core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f flist.f --top-module s1c88_tb -o s1c88_sim
	@out="$$(./obj_dir/s1c88_sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- bench/s1c88_tb.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_tb
    import cpu_pkg::*;
();

    localparam word_t VECTOR = 16'hFFF0;
    localparam int WAIT_LIMIT = 20000;

    logic  clk;
    logic  reset;
    byte_t data_in;
    word_t address_out;
    byte_t data_out;
    logic  read;
    logic  write;
    logic  sync;

    byte_t mem [0:65535];
    int    seed;
    word_t gen_pc;

    // expected writes and the self-jump address of the program under test
    word_t exp_addr [$];
    byte_t exp_data [$];
    word_t end_addr = 16'h0000;

    // what the bus monitor has seen since the last reset
    word_t read_log [$];
    word_t sync_log [$];
    int    wr_count = 0;
    int    end_hits = 0;
    logic  second_clock = 1'b0;

    string test_name;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    total_errors = 0;

    s1c88_core #(
        .VECTOR_ADDR (VECTOR)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .address_out (address_out),
        .data_out    (data_out),
        .read        (read),
        .write       (write),
        .sync        (sync)
    );

    assign data_in = mem[address_out];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic byte_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic start_program(input word_t start);
        word_t i;
        i = 16'h0000;
        do
        begin
            mem[i] = i[7:0] ^ i[15:8];
            i = i + 16'd1;
        end
        while (i != 16'h0000);
        mem[VECTOR] = start[7:0];
        mem[VECTOR + 16'd1] = start[15:8];
        gen_pc = start;
    endtask

    task automatic emit_byte(input byte_t value);
        mem[gen_pc] = value;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic emit_imm(input byte_t op, input byte_t value);
        emit_byte(op);
        emit_byte(value);
    endtask

    task automatic emit_abs(input byte_t op, input word_t addr);
        emit_byte(op);
        emit_byte(addr[7:0]);
        emit_byte(addr[15:8]);
    endtask

    // walks the program as the core should and returns the self-jump address
    function automatic word_t reference_run();
        word_t pc;
        word_t imm;
        byte_t op;
        byte_t a;
        byte_t b;
        logic [1:0] n;
        int steps;
        exp_addr.delete();
        exp_data.delete();
        pc = {mem[VECTOR + 16'd1], mem[VECTOR]};
        a = 8'h00;
        b = 8'h00;
        for (steps = 0; steps < 4096; steps++)
        begin
            op = mem[pc];
            n = operand_count(op);
            imm = {mem[pc + 16'd2], mem[pc + 16'd1]};
            if (n == 2'd1)
                imm[15:8] = 8'h00;
            if (op == OP_JP_ABS)
            begin
                if (imm == pc)
                    return pc;
                pc = imm;
            end
            else
            begin
                case (op)
                    OP_LD_A_IMM:
                        a = imm[7:0];
                    OP_LD_B_IMM:
                        b = imm[7:0];
                    OP_ADD_A_IMM:
                        a = a + imm[7:0];
                    OP_SUB_A_IMM:
                        a = a - imm[7:0];
                    OP_AND_A_IMM:
                        a = a & imm[7:0];
                    OP_OR_A_IMM:
                        a = a | imm[7:0];
                    OP_ST_A_ABS:
                    begin
                        exp_addr.push_back(imm);
                        exp_data.push_back(a);
                    end
                    OP_ST_B_ABS:
                    begin
                        exp_addr.push_back(imm);
                        exp_data.push_back(b);
                    end
                    default:
                        a = a;
                endcase
                pc = pc + 16'd1 + 16'(n);
            end
        end
        return pc;
    endfunction

    task automatic report_value(input string what, input word_t expected, input word_t actual);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic compare_write(input word_t addr, input byte_t data);
        if (wr_count < exp_addr.size())
        begin
            assert (addr == exp_addr[wr_count])
            else report_value("write address", exp_addr[wr_count], addr);
            assert (data == exp_data[wr_count])
            else report_value("write data", {8'h00, exp_data[wr_count]}, {8'h00, data});
        end
        else
        begin
            $display("%s: unexpected write to %h after all expected writes", test_name, addr);
            test_errors++;
        end
        wr_count++;
    endtask

    // bus monitor, sampled mid-cycle; a bus cycle is always two clocks long
    always @(negedge clk)
    begin
        if (!(read || write))
            second_clock = 1'b0;
        else if (!second_clock)
        begin
            second_clock = 1'b1;
            if (read && read_log.size() < 2)
                read_log.push_back(address_out);
            if (sync)
            begin
                sync_log.push_back(address_out);
                if (address_out == end_addr)
                    end_hits++;
            end
        end
        else
        begin
            second_clock = 1'b0;
            if (write)
            begin
                mem[address_out] = data_out;
                compare_write(address_out, data_out);
            end
        end
    end

    task automatic check_startup(input word_t start);
        assert (read_log.size() == 2 && sync_log.size() > 0)
        else
        begin
            $display("%s: no vector reads or opcode fetch after reset", test_name);
            test_errors++;
        end
        if (read_log.size() == 2 && sync_log.size() > 0)
        begin
            assert (read_log[0] == VECTOR)
            else report_value("vector low read", VECTOR, read_log[0]);
            assert (read_log[1] == VECTOR + 16'd1)
            else report_value("vector high read", VECTOR + 16'd1, read_log[1]);
            assert (sync_log[0] == start)
            else report_value("first opcode fetch", start, sync_log[0]);
        end
    endtask

    // the opcode fetch that follows the one at 'at' must be at 'expected'
    task automatic check_next_sync(input word_t at, input word_t expected);
        int i;
        int found;
        found = -1;
        for (i = 0; i + 1 < sync_log.size(); i++)
        begin
            if (found < 0 && sync_log[i] == at)
                found = i;
        end
        assert (found >= 0)
        else
        begin
            $display("%s: no opcode fetch at %h followed by another", test_name, at);
            test_errors++;
        end
        if (found >= 0)
        begin
            assert (sync_log[found + 1] == expected)
            else report_value("next opcode fetch", expected, sync_log[found + 1]);
        end
    endtask

    // closes the program with a self-jump, resets the core and runs it
    task automatic run_program(input word_t start);
        int cycles;
        emit_abs(OP_JP_ABS, gen_pc);
        end_addr = reference_run();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        read_log.delete();
        sync_log.delete();
        wr_count = 0;
        end_hits = 0;
        reset = 1'b0;
        cycles = 0;
        while (end_hits < 3 && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (end_hits < 3)
        begin
            $display("%s: timed out waiting for the self-jump at %h", test_name, end_addr);
            test_errors++;
        end
        assert (wr_count == exp_addr.size())
        else report_value("write count", 16'(exp_addr.size()), 16'(wr_count));
        check_startup(start);
    endtask

    task automatic finish_test();
        if (test_errors == 0)
            $display("test %s: passed", test_name);
        else
            $display("test %s: %0d errors", test_name, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
    endtask

    task automatic test_load_store();
        test_name = "load_store";
        test_errors = 0;
        start_program(16'h0100);
        emit_imm(OP_LD_A_IMM, rand_byte());
        emit_imm(OP_LD_B_IMM, rand_byte());
        emit_abs(OP_ST_A_ABS, 16'h8000);
        emit_abs(OP_ST_B_ABS, 16'h8001);
        emit_imm(OP_LD_A_IMM, rand_byte());
        emit_abs(OP_ST_B_ABS, 16'h8002);
        emit_abs(OP_ST_A_ABS, 16'h8003);
        run_program(16'h0100);
        finish_test();
    endtask

    task automatic test_alu_random();
        byte_t sel;
        int i;
        test_name = "alu_random";
        test_errors = 0;
        start_program(16'h0200);
        emit_imm(OP_LD_A_IMM, rand_byte());
        for (i = 0; i < 40; i++)
        begin
            sel = rand_byte();
            case (sel[1:0])
                2'd0:
                    emit_imm(OP_ADD_A_IMM, rand_byte());
                2'd1:
                    emit_imm(OP_SUB_A_IMM, rand_byte());
                2'd2:
                    emit_imm(OP_AND_A_IMM, rand_byte());
                default:
                    emit_imm(OP_OR_A_IMM, rand_byte());
            endcase
            emit_abs(OP_ST_A_ABS, 16'h8100 + 16'(i));
        end
        run_program(16'h0200);
        finish_test();
    endtask

    task automatic test_jump();
        word_t jp_at;
        test_name = "jump";
        test_errors = 0;
        start_program(16'h0300);
        emit_imm(OP_LD_A_IMM, rand_byte());
        emit_imm(OP_LD_B_IMM, rand_byte());
        jp_at = gen_pc;
        emit_abs(OP_JP_ABS, 16'h0340);
        // stores that the jump skips over
        emit_abs(OP_ST_A_ABS, 16'h8200);
        emit_abs(OP_ST_B_ABS, 16'h8201);
        gen_pc = 16'h0340;
        emit_abs(OP_ST_B_ABS, 16'h8202);
        emit_abs(OP_ST_A_ABS, 16'h8203);
        run_program(16'h0300);
        check_next_sync(jp_at, 16'h0340);
        finish_test();
    endtask

    task automatic test_undefined();
        word_t odd_at;
        test_name = "undefined_opcodes";
        test_errors = 0;
        start_program(16'h0400);
        emit_imm(OP_LD_A_IMM, rand_byte());
        odd_at = gen_pc;
        emit_byte(8'h55);
        emit_abs(OP_ST_A_ABS, 16'h8300);
        emit_byte(8'h00);
        emit_imm(OP_LD_B_IMM, rand_byte());
        emit_byte(8'hB2);
        emit_abs(OP_ST_B_ABS, 16'h8301);
        emit_byte(OP_NOP);
        emit_abs(OP_ST_A_ABS, 16'h8302);
        run_program(16'h0400);
        check_next_sync(odd_at, odd_at + 16'd1);
        finish_test();
    endtask

    initial
    begin
        seed = 32'h02280cec;
        reset = 1'b1;
        test_load_store();
        test_alu_random();
        test_jump();
        test_undefined();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
            total_errors);
        if (total_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/s1c88_checker.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_checker
    import cpu_pkg::*, bus_pkg::*;
(
    input wire logic  clk,
    input wire logic  reset,
    input wire word_t address_out,
    input wire byte_t data_out,
    input wire logic  read,
    input wire logic  write,
    input wire logic  sync
);

    // phase of the clock that has just ended, rebuilt from the bus strobes
    bus_phase_t last_phase;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            last_phase <= PH_IDLE;
        else if (read || write)
            last_phase <= (last_phase == PH_ADDR) ? PH_DATA : PH_ADDR;
        else
            last_phase <= PH_IDLE;
    end

    never_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high together");

    sync_only_with_read: assert property (@(posedge clk) disable iff (reset)
        sync |-> read)
        else $error("sync is high without read");

    // a cycle that starts on this clock must look the same on the next one
    cycle_is_stable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && last_phase != PH_ADDR |=>
            $stable(address_out) && $stable(read) && $stable(write) && $stable(sync)
            && (!write || $stable(data_out)))
        else $error("bus cycle changed between its two clocks");

endmodule

bind s1c88_core s1c88_checker checker_inst (
    .clk         (clk),
    .reset       (reset),
    .address_out (address_out),
    .data_out    (data_out),
    .read        (read),
    .write       (write),
    .sync        (sync)
);

`default_nettype wire

//--- hdl/s1c88_core.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_core
    import cpu_pkg::*, bus_pkg::*;
#(
    parameter word_t VECTOR_ADDR = 16'h0000
)
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire byte_t data_in,
    output word_t      address_out,
    output byte_t      data_out,
    output logic       read,
    output logic       write,
    output logic       sync
);

    logic    instr_valid;
    instr_t  instr;
    logic    ctrl_valid;
    ctrl_t   ctrl;
    logic    retire_valid;
    retire_t retire;

    // fetch owns the bus, the other two stages only see strobes
    fetch_unit #(
        .VECTOR_ADDR (VECTOR_ADDR)
    ) fetch_inst (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .retire_valid (retire_valid),
        .retire       (retire),
        .address_out  (address_out),
        .data_out     (data_out),
        .read         (read),
        .write        (write),
        .sync         (sync),
        .instr_valid  (instr_valid),
        .instr        (instr)
    );

    decode_unit decode_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl_valid  (ctrl_valid),
        .ctrl        (ctrl)
    );

    execute_unit execute_inst (
        .clk          (clk),
        .reset        (reset),
        .ctrl_valid   (ctrl_valid),
        .ctrl         (ctrl),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import cpu_pkg::*, bus_pkg::*;
#(
    parameter word_t VECTOR_ADDR = 16'h0000
)
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire byte_t   data_in,
    input  wire logic    retire_valid,
    input  wire retire_t retire,
    output word_t        address_out,
    output byte_t        data_out,
    output logic         read,
    output logic         write,
    output logic         sync,
    output logic         instr_valid,
    output instr_t       instr
);

    typedef enum logic [2:0] {
        ST_RESET_WAIT,
        ST_VEC_LO,
        ST_VEC_HI,
        ST_OPCODE,
        ST_OPERAND,
        ST_ISSUE,
        ST_WAIT,
        ST_WRITE
    } fetch_state_t;

    fetch_state_t state;
    bus_phase_t   phase;
    logic         wait_cnt;
    logic         opnd_idx;
    logic [1:0]   operand_cnt;
    word_t        pc;

    assign read = (phase != PH_IDLE) &&
        (state inside {ST_VEC_LO, ST_VEC_HI, ST_OPCODE, ST_OPERAND});
    assign write = (phase != PH_IDLE) && (state == ST_WRITE);
    assign sync = (phase != PH_IDLE) && (state == ST_OPCODE);

    // the instruction is handed over for exactly one clock
    assign instr_valid = (state == ST_ISSUE);

    // every byte read lands on the edge that closes the data phase
    always_ff @(posedge clk)
    begin
        if (phase == PH_DATA)
        begin
            case (state)
                ST_VEC_LO:
                    pc[7:0] <= data_in;
                ST_VEC_HI:
                    pc[15:8] <= data_in;
                ST_OPCODE:
                begin
                    instr.opcode <= data_in;
                    instr.imm <= '0;
                    operand_cnt <= operand_count(data_in);
                    pc <= pc + 16'd1;
                end
                ST_OPERAND:
                begin
                    if (opnd_idx)
                        instr.imm[15:8] <= data_in;
                    else
                        instr.imm[7:0] <= data_in;
                    pc <= pc + 16'd1;
                end
                default:
                    pc <= pc;
            endcase
        end
        if (state == ST_WAIT && retire_valid)
        begin
            if (retire.kind == RET_JUMP)
                pc <= retire.addr;
            if (retire.kind == RET_WRITE)
                data_out <= retire.data;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= ST_RESET_WAIT;
            phase <= PH_IDLE;
            wait_cnt <= 1'b0;
            opnd_idx <= 1'b0;
            address_out <= '0;
        end
        else if (phase == PH_ADDR)
        begin
            phase <= PH_DATA;
        end
        else
        begin
            case (state)
                ST_RESET_WAIT:
                begin
                    wait_cnt <= 1'b1;
                    if (wait_cnt)
                    begin
                        state <= ST_VEC_LO;
                        phase <= PH_ADDR;
                        address_out <= VECTOR_ADDR;
                    end
                end
                ST_VEC_LO:
                begin
                    state <= ST_VEC_HI;
                    phase <= PH_ADDR;
                    address_out <= VECTOR_ADDR + 16'd1;
                end
                ST_VEC_HI:
                begin
                    // the high byte is still on data_in, so jump straight to it
                    state <= ST_OPCODE;
                    phase <= PH_ADDR;
                    address_out <= {data_in, pc[7:0]};
                end
                ST_OPCODE:
                begin
                    opnd_idx <= 1'b0;
                    if (operand_count(data_in) == 2'd0)
                    begin
                        state <= ST_ISSUE;
                        phase <= PH_IDLE;
                    end
                    else
                    begin
                        state <= ST_OPERAND;
                        phase <= PH_ADDR;
                        address_out <= pc + 16'd1;
                    end
                end
                ST_OPERAND:
                begin
                    if ({1'b0, opnd_idx} + 2'd1 == operand_cnt)
                    begin
                        state <= ST_ISSUE;
                        phase <= PH_IDLE;
                    end
                    else
                    begin
                        opnd_idx <= 1'b1;
                        phase <= PH_ADDR;
                        address_out <= pc + 16'd1;
                    end
                end
                ST_ISSUE:
                    state <= ST_WAIT;
                ST_WAIT:
                begin
                    if (retire_valid)
                    begin
                        phase <= PH_ADDR;
                        case (retire.kind)
                            RET_WRITE:
                            begin
                                state <= ST_WRITE;
                                address_out <= retire.addr;
                            end
                            RET_JUMP:
                            begin
                                state <= ST_OPCODE;
                                address_out <= retire.addr;
                            end
                            default:
                            begin
                                state <= ST_OPCODE;
                                address_out <= pc;
                            end
                        endcase
                    end
                end
                ST_WRITE:
                begin
                    state <= ST_OPCODE;
                    phase <= PH_ADDR;
                    address_out <= pc;
                end
                default:
                    state <= ST_RESET_WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
    import cpu_pkg::*, bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  ctrl_valid,
    input  wire ctrl_t ctrl,
    output logic       retire_valid,
    output retire_t    retire
);

    byte_t reg_a;
    byte_t reg_b;
    byte_t alu_r;

    // immediates are always the second ALU operand
    alu alu_inst
    (
        .op (ctrl.alu_op),
        .a  (reg_a),
        .b  (ctrl.imm[7:0]),
        .r  (alu_r)
    );

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            reg_a <= '0;
            reg_b <= '0;
        end
        else if (ctrl_valid)
        begin
            if (ctrl.dest_a)
                reg_a <= alu_r;
            if (ctrl.dest_b)
                reg_b <= alu_r;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= ctrl_valid;
    end

    // the store reads the registers before any update, stores never write them
    always_ff @(posedge clk)
    begin
        if (ctrl_valid)
        begin
            retire.addr <= ctrl.imm;
            retire.data <= ctrl.store_src_b ? reg_b : reg_a;
            if (ctrl.store)
                retire.kind <= RET_WRITE;
            else if (ctrl.jump)
                retire.kind <= RET_JUMP;
            else
                retire.kind <= RET_NEXT;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit
    import cpu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   instr_valid,
    input  wire instr_t instr,
    output logic        ctrl_valid,
    output ctrl_t       ctrl
);

    ctrl_t ctrl_next;

    // opcode table, anything unknown falls through as a NOP
    always_comb
    begin
        ctrl_next = '0;
        ctrl_next.alu_op = ALU_PASS;
        ctrl_next.imm = instr.imm;
        case (instr.opcode)
            OP_LD_A_IMM:
                ctrl_next.dest_a = 1'b1;
            OP_LD_B_IMM:
                ctrl_next.dest_b = 1'b1;
            OP_ADD_A_IMM:
            begin
                ctrl_next.alu_op = ALU_ADD;
                ctrl_next.dest_a = 1'b1;
            end
            OP_SUB_A_IMM:
            begin
                ctrl_next.alu_op = ALU_SUB;
                ctrl_next.dest_a = 1'b1;
            end
            OP_AND_A_IMM:
            begin
                ctrl_next.alu_op = ALU_AND;
                ctrl_next.dest_a = 1'b1;
            end
            OP_OR_A_IMM:
            begin
                ctrl_next.alu_op = ALU_OR;
                ctrl_next.dest_a = 1'b1;
            end
            OP_ST_A_ABS:
                ctrl_next.store = 1'b1;
            OP_ST_B_ABS:
            begin
                ctrl_next.store = 1'b1;
                ctrl_next.store_src_b = 1'b1;
            end
            OP_JP_ABS:
                ctrl_next.jump = 1'b1;
            default:
                ctrl_next.jump = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
            ctrl <= ctrl_next;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            ctrl_valid <= 1'b0;
        else
            ctrl_valid <= instr_valid;
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire alu_op_t op,
    input  wire byte_t   a,
    input  wire byte_t   b,
    output byte_t        r
);

    // all arithmetic wraps at 8 bits, no flags are kept
    always_comb
    begin
        case (op)
            ALU_ADD:
                r = a + b;
            ALU_SUB:
                r = a - b;
            ALU_AND:
                r = a & b;
            ALU_OR:
                r = a | b;
            default:
                r = b;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    import cpu_pkg::*;

    // position inside a two clock bus cycle
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ADDR,
        PH_DATA
    } bus_phase_t;

    // what fetch has to do once an instruction has executed
    typedef enum logic [1:0] {
        RET_NEXT,
        RET_WRITE,
        RET_JUMP
    } retire_kind_t;

    typedef struct packed {
        retire_kind_t kind;
        word_t        addr;
        byte_t        data;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // opcode map of the kept subset, loosely following the S1C88 table
    localparam byte_t OP_NOP       = 8'hFF;
    localparam byte_t OP_LD_A_IMM  = 8'hB0;
    localparam byte_t OP_LD_B_IMM  = 8'hB1;
    localparam byte_t OP_ADD_A_IMM = 8'h02;
    localparam byte_t OP_SUB_A_IMM = 8'h12;
    localparam byte_t OP_AND_A_IMM = 8'h22;
    localparam byte_t OP_OR_A_IMM  = 8'h2A;
    localparam byte_t OP_ST_A_ABS  = 8'hBC;
    localparam byte_t OP_ST_B_ABS  = 8'hBD;
    localparam byte_t OP_JP_ABS    = 8'hF2;

    // number of immediate bytes that follow the opcode
    function automatic logic [1:0] operand_count(input byte_t opcode);
        logic [1:0] n;
        case (opcode)
            OP_LD_A_IMM, OP_LD_B_IMM, OP_ADD_A_IMM, OP_SUB_A_IMM,
            OP_AND_A_IMM, OP_OR_A_IMM:
                n = 2'd1;
            OP_ST_A_ABS, OP_ST_B_ABS, OP_JP_ABS:
                n = 2'd2;
            default:
                n = 2'd0;
        endcase
        return n;
    endfunction

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    typedef struct packed {
        byte_t opcode;
        word_t imm;
    } instr_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    dest_a;
        logic    dest_b;
        logic    store;
        logic    store_src_b;
        logic    jump;
        word_t   imm;
    } ctrl_t;

endpackage

`default_nettype wire
